// File: Makefile
SRCS := $(shell grep -v '^+' list.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_snes_cart: $(SRCS) list.f
	verilator --binary --assert --timing -Wno-fatal --timescale 1ns/10ps \
		--top-module tb_snes_cart -f list.f -Mdir obj_dir

run: obj_dir/Vtb_snes_cart
	./obj_dir/Vtb_snes_cart +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/cart_pkg.sv
/*
 * cartridge core shared definitions
 * header offsets, mask sizing, MSU playback constants
 * and the cheat code word layout
 */
`default_nettype none

package cart_pkg;

	// ========================================
	// rom header detection
	// ========================================
	// copier header in front of the image
	localparam logic [24:0] HDR_OFS           = 25'h200;
	localparam logic [24:0] LOROM_SIZE_ADDR   = 25'h7FD6 + HDR_OFS;
	localparam logic [24:0] LOROM_RAM_ADDR    = 25'h7FD8 + HDR_OFS;
	localparam logic [24:0] HIROM_SIZE_ADDR   = 25'hFFD6 + HDR_OFS;
	localparam logic [24:0] HIROM_RAM_ADDR    = 25'hFFD8 + HDR_OFS;
	localparam logic [24:0] EXHIROM_SIZE_ADDR = 25'h40FFD6 + HDR_OFS;
	localparam logic [24:0] EXHIROM_RAM_ADDR  = 25'h40FFD8 + HDR_OFS;
	localparam logic [3:0]  DEF_ROM_SIZE      = 4'hC;
	localparam int          MASK_W            = 24;
	// one size step is 1 KiB
	localparam logic [MASK_W-1:0] MASK_BASE   = 24'd1024;

	// ========================================
	// msu audio
	// ========================================
	localparam int SAMPLE_DIV  = 486;
	localparam int DIV_W       = $clog2(SAMPLE_DIV + 1);
	localparam int FIFO_AW     = 12;
	// refill threshold in words
	localparam int FIFO_REFILL = 1176;
	localparam int LBA_W       = 21;
	localparam int START_FRAME = 1;
	localparam int AUDIO_W     = 16;

	// fetch fsm states
	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_ACK   = 2'd1;
	localparam logic [1:0] ST_DRAIN = 2'd2;

	// ========================================
	// cheat code
	// ========================================
	// flags sit lowest so word k maps to byte offset 2k
	typedef struct packed {
		logic [31:0] replace;
		logic [31:0] compare;
		logic [31:0] address;
		logic [31:0] flags;
	} cheat_fields_t;

	typedef union packed {
		logic [7:0][15:0] words;
		cheat_fields_t    fields;
	} cheat_code_u;

endpackage

`default_nettype wire

// File: common/dl_if.sv
/*
 * download bus
 * address, data and write strobe of the image download,
 * plus levels telling a cartridge from a cheat file
 */
`timescale 1ns/10ps
`default_nettype none

interface dl_if;
	logic [24:0] addr;
	logic [15:0] dout;
	// one cycle per word
	logic        wr;
	// high through a cartridge download
	logic        cart;
	// high through a cheat file download
	logic        code;

	modport src (output addr, dout, wr, cart, code);
	modport snk (input addr, dout, wr, cart, code);
endinterface

`default_nettype wire

// File: list.f
common/cart_pkg.sv
common/dl_if.sv
loader/cart_loader_decode.sv
loader/cheat_code_loader.sv
msu/msu_sector_fetch.sv
msu/msu_audio_out.sv
rtl/snes_cart_top.sv
tests/snes_cart_assert.sv
tests/tb_snes_cart.sv

// File: loader/cart_loader_decode.sv
/*
 * cartridge download decoder
 * splits downloads into cartridge and cheat streams,
 * picks mapper type, rom/ram sizes and region out of the image header
 */
`timescale 1ns/10ps
`default_nettype none

module cart_loader_decode
	import cart_pkg::*;
(
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              ioctl_download,
	input  logic [7:0]        ioctl_index,
	input  logic [24:0]       ioctl_addr,
	input  logic [15:0]       ioctl_dout,
	input  logic              ioctl_wr,
	input  logic [2:0]        lhrom_type,
	input  logic [1:0]        region_sel,
	dl_if.src                 dl,
	output logic [7:0]        rom_type,
	output logic [MASK_W-1:0] rom_mask,
	output logic [MASK_W-1:0] ram_mask,
	output logic              pal
);

	logic        code_idx;
	logic        cart_dl;
	logic        hdr_en;
	logic [24:0] size_addr;
	logic [24:0] ram_addr;
	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        rom_region;

	// index all ones is a cheat file
	assign code_idx = &ioctl_index;
	assign cart_dl  = ioctl_download & ~code_idx;

	assign dl.addr = ioctl_addr;
	assign dl.dout = ioctl_dout;
	assign dl.wr   = ioctl_wr;
	assign dl.cart = cart_dl;
	assign dl.code = ioctl_download & code_idx;

	// header byte positions per forced layout
	always_comb begin
		hdr_en    = 1'b1;
		size_addr = LOROM_SIZE_ADDR;
		ram_addr  = LOROM_RAM_ADDR;
		case (lhrom_type)
			3'd3: begin
				size_addr = HIROM_SIZE_ADDR;
				ram_addr  = HIROM_RAM_ADDR;
			end
			3'd4: begin
				size_addr = EXHIROM_SIZE_ADDR;
				ram_addr  = EXHIROM_RAM_ADDR;
			end
			3'd2: hdr_en = 1'b1;
			default: hdr_en = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= DEF_ROM_SIZE;
			ram_size   <= 4'h0;
			rom_region <= 1'b0;
			rom_type   <= 8'h00;
			rom_mask   <= '0;
			ram_mask   <= '0;
			pal        <= 1'b0;
		end else if (cart_dl) begin
			if (ioctl_wr) begin
				// sizes default on the first word unless auto mode finds them
				if (ioctl_addr == 25'd0) begin
					rom_size <= DEF_ROM_SIZE;
					ram_size <= 4'h0;
					if (lhrom_type == 3'd0 && ioctl_dout[7:0] != 8'h00)
						{ram_size, rom_size} <= ioctl_dout[7:0];
					case (lhrom_type)
						3'd1, 3'd2: rom_type <= 8'd0;
						3'd3:       rom_type <= 8'd1;
						3'd4:       rom_type <= 8'd2;
						default:    rom_type <= ioctl_dout[15:8];
					endcase
				end
				if (ioctl_addr == 25'd2)
					rom_region <= ioctl_dout[8];
				// sizes from the internal header in a forced layout
				if (hdr_en && ioctl_addr == size_addr)
					rom_size <= ioctl_dout[11:8];
				if (hdr_en && ioctl_addr == ram_addr)
					ram_size <= ioctl_dout[3:0];
				// masks lag the size codes by one write
				rom_mask <= (MASK_BASE << rom_size) - 1'b1;
				ram_mask <= (ram_size != 4'h0) ? (MASK_BASE << ram_size) - 1'b1 : '0;
			end
		end else begin
			// region held while the image loads
			pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];
		end
	end

endmodule

`default_nettype wire

// File: loader/cheat_code_loader.sv
/*
 * cheat code loader
 * collects eight 16-bit words of a cheat file into one code
 * and strobes it once the last word is in
 */
`timescale 1ns/10ps
`default_nettype none

module cheat_code_loader
	import cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        RESET,
	dl_if.snk           dl,
	output cheat_code_u gg_code,
	output logic        gg_code_valid
);

	logic code_wr;

	// even addresses only carry words
	assign code_wr = dl.code & dl.wr & ~dl.addr[0];

	// strobe after the replace top word
	always_ff @(posedge clk_sys) begin
		if (RESET)
			gg_code_valid <= 1'b0;
		else
			gg_code_valid <= code_wr & (dl.addr[3:0] == 4'd14);
	end

	// codes of a previous game dropped on a new cartridge
	always_ff @(posedge clk_sys) begin
		if (dl.cart)
			gg_code <= '0;
		else if (code_wr)
			gg_code.words[dl.addr[3:1]] <= dl.dout;
	end

endmodule

`default_nettype wire

// File: msu/msu_audio_out.sv
/*
 * msu audio output
 * sector word FIFO, sample rate divider, left/right alternation
 * and mixing into the main console audio
 */
`timescale 1ns/10ps
`default_nettype none

module msu_audio_out
	import cart_pkg::*;
(
	input  logic               clk_sys,
	input  logic               RESET,
	input  logic               play,
	input  logic               msu_trackmounting,
	input  logic               sd_ack,
	input  logic               sd_buff_wr,
	input  logic [AUDIO_W-1:0] sd_buff_din,
	input  logic [AUDIO_W-1:0] main_audio_l,
	input  logic [AUDIO_W-1:0] main_audio_r,
	output logic [FIFO_AW-1:0] fifo_level,
	output logic [AUDIO_W-1:0] audio_l,
	output logic [AUDIO_W-1:0] audio_r
);

	logic [AUDIO_W-1:0] mem [2**FIFO_AW];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               full;
	logic               empty;
	logic               push;
	logic               pop;
	logic               tick;
	logic [DIV_W-1:0]   div_cnt;
	logic               chan_left;
	logic               sd_ack_d;
	logic [AUDIO_W-1:0] samp_l;
	logic [AUDIO_W-1:0] samp_r;

	// ========================================
	// sample FIFO
	// ========================================
	assign full  = count[FIFO_AW];
	assign empty = (count == '0);
	assign push  = sd_ack & sd_buff_wr & play & ~msu_trackmounting & ~full;
	assign pop   = tick & ~empty & play & ~msu_trackmounting;
	// saturate so a full FIFO never reads as empty
	assign fifo_level = full ? '1 : count[FIFO_AW-1:0];

	always_ff @(posedge clk_sys) begin
		if (push)
			mem[wr_ptr] <= sd_buff_din;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// ========================================
	// sample clock and channels
	// ========================================
	assign tick = (div_cnt == '0);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			div_cnt   <= DIV_W'(SAMPLE_DIV);
			chan_left <= 1'b1;
			sd_ack_d  <= 1'b0;
			samp_l    <= '0;
			samp_r    <= '0;
		end else begin
			sd_ack_d <= sd_ack;
			if (tick) begin
				div_cnt   <= DIV_W'(SAMPLE_DIV);
				chan_left <= ~chan_left;
				// left word first, then right
				if (pop && chan_left)
					samp_l <= mem[rd_ptr];
				else if (pop)
					samp_r <= mem[rd_ptr];
			end else begin
				div_cnt <= div_cnt - 1'b1;
			end
			// new sector realigns on left
			if (sd_ack && !sd_ack_d)
				chan_left <= 1'b1;
		end
	end

	// plain wraparound add without clamping
	always_ff @(posedge clk_sys) begin
		audio_l <= play ? main_audio_l + samp_l : main_audio_l;
		audio_r <= play ? main_audio_r + samp_r : main_audio_r;
	end

endmodule

`default_nettype wire

// File: msu/msu_sector_fetch.sv
/*
 * msu sector fetch
 * requests consecutive track sectors while playing,
 * paced by the sample FIFO level, stops at the end frame
 */
`timescale 1ns/10ps
`default_nettype none

module msu_sector_fetch
	import cart_pkg::*;
(
	input  logic               clk_sys,
	input  logic               RESET,
	input  logic               msu_trig_play,
	input  logic               msu_trackmounting,
	input  logic [LBA_W-1:0]   msu_end_frame,
	input  logic               sd_ack,
	input  logic [FIFO_AW-1:0] fifo_level,
	output logic [31:0]        sd_lba,
	output logic               sd_rd,
	output logic               msu_audio_play
);

	logic [1:0]       state;
	logic [LBA_W-1:0] cur_frame;
	logic             refill_ok;

	// sector done and room for another one
	assign refill_ok = ~sd_ack && (fifo_level <= FIFO_AW'(FIFO_REFILL));

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state          <= ST_IDLE;
			sd_rd          <= 1'b0;
			sd_lba         <= '0;
			cur_frame      <= LBA_W'(START_FRAME);
			msu_audio_play <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (msu_audio_play && !msu_trackmounting) begin
					sd_lba <= 32'(cur_frame);
					sd_rd  <= 1'b1;
					state  <= ST_ACK;
				end
				// host picked up the request
				ST_ACK: if (sd_ack) begin
					sd_rd <= 1'b0;
					state <= ST_DRAIN;
				end
				ST_DRAIN: if (refill_ok) begin
					if (msu_audio_play && cur_frame < msu_end_frame) begin
						cur_frame <= cur_frame + 1'b1;
						sd_lba    <= sd_lba + 32'd1;
						sd_rd     <= 1'b1;
						state     <= ST_ACK;
					end else begin
						// end of track in stop mode
						msu_audio_play <= 1'b0;
						state          <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
			// new trigger wins over a stop in the same cycle
			if (msu_trig_play) begin
				msu_audio_play <= 1'b1;
				cur_frame      <= LBA_W'(START_FRAME);
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/snes_cart_top.sv
/*
 * cartridge side top level
 * download decoding, cheat loading and streamed msu audio
 */
`timescale 1ns/10ps
`default_nettype none

module snes_cart_top
	import cart_pkg::*;
(
	input  logic               clk_sys,
	input  logic               RESET,
	// download
	input  logic               ioctl_download,
	input  logic [7:0]         ioctl_index,
	input  logic [24:0]        ioctl_addr,
	input  logic [15:0]        ioctl_dout,
	input  logic               ioctl_wr,
	input  logic [2:0]         lhrom_type,
	input  logic [1:0]         region_sel,
	output logic [7:0]         rom_type,
	output logic [MASK_W-1:0]  rom_mask,
	output logic [MASK_W-1:0]  ram_mask,
	output logic               pal,
	output cheat_code_u        gg_code,
	output logic               gg_code_valid,
	// msu track streaming
	input  logic               msu_trig_play,
	input  logic               msu_trackmounting,
	input  logic [LBA_W-1:0]   msu_end_frame,
	input  logic               sd_ack,
	input  logic               sd_buff_wr,
	input  logic [AUDIO_W-1:0] sd_buff_din,
	output logic [31:0]        sd_lba,
	output logic               sd_rd,
	output logic               msu_audio_play,
	// audio
	input  logic [AUDIO_W-1:0] main_audio_l,
	input  logic [AUDIO_W-1:0] main_audio_r,
	output logic [AUDIO_W-1:0] audio_l,
	output logic [AUDIO_W-1:0] audio_r
);

	logic [FIFO_AW-1:0] fifo_level;

	dl_if dl ();

	cart_loader_decode i_cart_loader_decode (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.lhrom_type     (lhrom_type),
		.region_sel     (region_sel),
		.dl             (dl.src),
		.rom_type       (rom_type),
		.rom_mask       (rom_mask),
		.ram_mask       (ram_mask),
		.pal            (pal)
	);

	cheat_code_loader i_cheat_code_loader (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.dl            (dl.snk),
		.gg_code       (gg_code),
		.gg_code_valid (gg_code_valid)
	);

	msu_sector_fetch i_msu_sector_fetch (
		.clk_sys           (clk_sys),
		.RESET             (RESET),
		.msu_trig_play     (msu_trig_play),
		.msu_trackmounting (msu_trackmounting),
		.msu_end_frame     (msu_end_frame),
		.sd_ack            (sd_ack),
		.fifo_level        (fifo_level),
		.sd_lba            (sd_lba),
		.sd_rd             (sd_rd),
		.msu_audio_play    (msu_audio_play)
	);

	msu_audio_out i_msu_audio_out (
		.clk_sys           (clk_sys),
		.RESET             (RESET),
		.play              (msu_audio_play),
		.msu_trackmounting (msu_trackmounting),
		.sd_ack            (sd_ack),
		.sd_buff_wr        (sd_buff_wr),
		.sd_buff_din       (sd_buff_din),
		.main_audio_l      (main_audio_l),
		.main_audio_r      (main_audio_r),
		.fifo_level        (fifo_level),
		.audio_l           (audio_l),
		.audio_r           (audio_r)
	);

endmodule

`default_nettype wire

// File: tests/snes_cart_assert.sv
/*
 * bound checks on the cartridge top level
 * reset values, cheat strobe width, sector range,
 * fetch handshake and unmixed audio while idle
 */
`timescale 1ns/10ps
`default_nettype none

module snes_cart_assert
	import cart_pkg::*;
(
	input logic               clk_sys,
	input logic               RESET,
	input logic               sd_rd,
	input logic               sd_ack,
	input logic [31:0]        sd_lba,
	input logic [LBA_W-1:0]   msu_end_frame,
	input logic               msu_audio_play,
	input logic               gg_code_valid,
	input logic [AUDIO_W-1:0] main_audio_l,
	input logic [AUDIO_W-1:0] main_audio_r,
	input logic [AUDIO_W-1:0] audio_l,
	input logic [AUDIO_W-1:0] audio_r
);

	// assertion failures so far
	int fail_cnt = 0;

	// strobes and play flag come out of reset low
	reset_low: assert property (@(posedge clk_sys)
		RESET |=> !sd_rd && !gg_code_valid && !msu_audio_play)
	else begin
		$error("sd_rd, gg_code_valid or msu_audio_play high after reset");
		fail_cnt++;
	end

	// cheat strobe lasts one cycle
	code_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		gg_code_valid |=> !gg_code_valid)
	else begin
		$error("gg_code_valid held high for more than one cycle");
		fail_cnt++;
	end

	// never past the last frame of the track
	lba_range: assert property (@(posedge clk_sys) disable iff (RESET)
		sd_lba <= 32'(msu_end_frame))
	else begin
		$error("sd_lba went beyond msu_end_frame");
		fail_cnt++;
	end

	// request only withdrawn once the host acknowledged
	rd_drop: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(sd_rd) |-> $past(sd_ack))
	else begin
		$error("sd_rd dropped without sd_ack");
		fail_cnt++;
	end

	// no msu sample mixed in while stopped
	idle_mix: assert property (@(posedge clk_sys) disable iff (RESET)
		!msu_audio_play |=> audio_l == $past(main_audio_l) && audio_r == $past(main_audio_r))
	else begin
		$error("audio output differs from main audio while play is low");
		fail_cnt++;
	end

endmodule

`default_nettype wire

// File: tests/tb_snes_cart.sv
/*
 * testbench for the cartridge side top level
 * hirom header detection, cheat loading, msu sector fetch
 * and audio mixing, with a simple sector source model
 */
`timescale 1ns/10ps
`default_nettype none

module tb_snes_cart
	import cart_pkg::*;
();

	localparam int     END_FRAME    = 3;
	localparam int     SECTOR_WORDS = 256;
	// two sample periods of host latency per sector
	localparam int     ACK_DELAY    = 2 * (SAMPLE_DIV + 1);
	// bound on fetching the whole track
	localparam int     TRACK_CYCLES = 2 * END_FRAME * (ACK_DELAY + SECTOR_WORDS + 8);
	// whole track at the sample rate plus slack
	localparam longint WATCHDOG_NS  =
		longint'(END_FRAME * SECTOR_WORDS * (SAMPLE_DIV + 1) + 20000) * 10;

	logic               clk_sys;
	logic               RESET;
	logic               ioctl_download;
	logic [7:0]         ioctl_index;
	logic [24:0]        ioctl_addr;
	logic [15:0]        ioctl_dout;
	logic               ioctl_wr;
	logic [2:0]         lhrom_type;
	logic [1:0]         region_sel;
	logic [7:0]         rom_type;
	logic [MASK_W-1:0]  rom_mask;
	logic [MASK_W-1:0]  ram_mask;
	logic               pal;
	cheat_code_u        gg_code;
	logic               gg_code_valid;
	logic               msu_trig_play;
	logic               msu_trackmounting;
	logic [LBA_W-1:0]   msu_end_frame;
	logic               sd_ack;
	logic               sd_buff_wr;
	logic [AUDIO_W-1:0] sd_buff_din;
	logic [31:0]        sd_lba;
	logic               sd_rd;
	logic               msu_audio_play;
	logic [AUDIO_W-1:0] main_audio_l = '0;
	logic [AUDIO_W-1:0] main_audio_r = '0;
	logic [AUDIO_W-1:0] audio_l;
	logic [AUDIO_W-1:0] audio_r;

	int          tb_errors = 0;
	int          valid_cnt = 0;
	logic [31:0] rnd_state = 32'd11228;
	logic [31:0] mix_state = 32'd11228;
	// every sector number the model was asked for
	logic [31:0] lba_seen [$];
	logic [15:0] cheat_w [8];
	logic [15:0] prev_main_l = '0;
	logic [15:0] prev_main_r = '0;
	logic        prev_play = 1'b0;
	// an msu sample showed up on the channel
	bit          mix_l_seen = 1'b0;
	bit          mix_r_seen = 1'b0;

	snes_cart_top i_snes_cart_top (.*);

	bind snes_cart_top snes_cart_assert i_snes_cart_assert (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.sd_rd          (sd_rd),
		.sd_ack         (sd_ack),
		.sd_lba         (sd_lba),
		.msu_end_frame  (msu_end_frame),
		.msu_audio_play (msu_audio_play),
		.gg_code_valid  (gg_code_valid),
		.main_audio_l   (main_audio_l),
		.main_audio_r   (main_audio_r),
		.audio_l        (audio_l),
		.audio_r        (audio_r)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// msu part is zero or a word of some fetched sector
	function automatic bit mix_ok(input logic [15:0] diff);
		if (diff == 16'h0)
			return 1'b1;
		foreach (lba_seen[i])
			if (diff == 16'h1000 + lba_seen[i][15:0])
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %s: got %h expected %h", name, got, exp);
			tb_errors++;
		end
	endtask

	// one download word with a single cycle strobe
	task automatic load_word(input logic [24:0] addr, input logic [15:0] data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		@(negedge clk_sys);
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, the run did not finish within the track length");
		$display("Test failed");
		$finish;
	end

	always @(negedge clk_sys) begin
		if (gg_code_valid)
			valid_cnt++;
	end

	// ========================================
	// sector source model
	// ========================================
	initial begin : sector_model
		sd_ack      = 1'b0;
		sd_buff_wr  = 1'b0;
		sd_buff_din = '0;
		forever begin
			@(negedge clk_sys);
			if (sd_rd && !sd_ack) begin
				lba_seen.push_back(sd_lba);
				// host latency before the sector arrives
				repeat (ACK_DELAY) @(negedge clk_sys);
				sd_ack = 1'b1;
				for (int i = 0; i < SECTOR_WORDS; i++) begin
					@(negedge clk_sys);
					sd_buff_wr  = 1'b1;
					sd_buff_din = 16'h1000 + sd_lba[15:0];
				end
				@(negedge clk_sys);
				sd_buff_wr = 1'b0;
				sd_ack     = 1'b0;
			end
		end
	end

	// main audio stimulus and check of the mixed output
	always @(negedge clk_sys) begin : mix_check
		logic [15:0] diff_l;
		logic [15:0] diff_r;
		diff_l = audio_l - prev_main_l;
		diff_r = audio_r - prev_main_r;
		if (prev_play) begin
			assert (mix_ok(diff_l)) else begin
				$display("[FAIL] audio_l: got %h main %h", audio_l, prev_main_l);
				tb_errors++;
			end
			assert (mix_ok(diff_r)) else begin
				$display("[FAIL] audio_r: got %h main %h", audio_r, prev_main_r);
				tb_errors++;
			end
			if (diff_l != 16'h0)
				mix_l_seen = 1'b1;
			if (diff_r != 16'h0)
				mix_r_seen = 1'b1;
		end
		mix_state    = lcg_next(mix_state);
		main_audio_l = mix_state[31:16];
		main_audio_r = mix_state[15:0];
		prev_main_l  = main_audio_l;
		prev_main_r  = main_audio_r;
		prev_play    = msu_audio_play;
	end

	initial begin : main_seq
		int wait_cnt;
		int total;
		RESET             = 1'b1;
		ioctl_download    = 1'b0;
		ioctl_index       = 8'h00;
		ioctl_addr        = '0;
		ioctl_dout        = '0;
		ioctl_wr          = 1'b0;
		lhrom_type        = 3'd0;
		region_sel        = 2'd0;
		msu_trig_play     = 1'b0;
		msu_trackmounting = 1'b0;
		msu_end_frame     = LBA_W'(END_FRAME);
		repeat (3) @(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);

		// ========================================
		// hirom header with the region bit at address 2
		// ========================================
		lhrom_type     = 3'd3;
		ioctl_download = 1'b1;
		load_word(25'd0, 16'h0000);
		load_word(25'd2, 16'h0100);
		load_word(HIROM_SIZE_ADDR, 16'h0A00);
		load_word(HIROM_RAM_ADDR, 16'h0003);
		// masks settle one write later
		load_word(HIROM_RAM_ADDR + 25'd2, 16'h0000);
		ioctl_download = 1'b0;
		check_value("rom_type", 32'(rom_type), 32'd1);
		check_value("rom_mask", 32'(rom_mask), (32'd1024 << 10) - 32'd1);
		check_value("ram_mask", 32'(ram_mask), (32'd1024 << 3) - 32'd1);
		repeat (2) @(negedge clk_sys);
		check_value("pal", 32'(pal), 32'd1);
		region_sel = 2'd1;
		repeat (2) @(negedge clk_sys);
		check_value("pal", 32'(pal), 32'd0);
		region_sel = 2'd2;
		repeat (2) @(negedge clk_sys);
		check_value("pal", 32'(pal), 32'd1);
		region_sel = 2'd0;

		// ========================================
		// cheat code of eight random words
		// ========================================
		ioctl_index    = 8'hFF;
		ioctl_download = 1'b1;
		for (int k = 0; k < 8; k++) begin
			rnd_state  = lcg_next(rnd_state);
			cheat_w[k] = rnd_state[31:16];
			load_word(25'(2 * k), cheat_w[k]);
		end
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_value("gg_code_valid pulses", 32'(valid_cnt), 32'd1);
		check_value("gg_code.flags", gg_code.fields.flags, {cheat_w[1], cheat_w[0]});
		check_value("gg_code.address", gg_code.fields.address, {cheat_w[3], cheat_w[2]});
		check_value("gg_code.compare", gg_code.fields.compare, {cheat_w[5], cheat_w[4]});
		check_value("gg_code.replace", gg_code.fields.replace, {cheat_w[7], cheat_w[6]});

		// ========================================
		// msu track of END_FRAME sectors
		// ========================================
		msu_trig_play = 1'b1;
		@(negedge clk_sys);
		msu_trig_play = 1'b0;
		wait_cnt = 0;
		while (msu_audio_play && wait_cnt < TRACK_CYCLES) begin
			@(negedge clk_sys);
			wait_cnt++;
		end
		if (msu_audio_play) begin
			$display("msu_audio_play stayed high after the last sector");
			tb_errors++;
		end
		check_value("sector count", 32'(lba_seen.size()), 32'(END_FRAME));
		foreach (lba_seen[i])
			check_value("sd_lba", lba_seen[i], 32'(i + 1));
		assert (mix_l_seen) else begin
			$display("no msu sample was mixed into audio_l during playback");
			tb_errors++;
		end
		assert (mix_r_seen) else begin
			$display("no msu sample was mixed into audio_r during playback");
			tb_errors++;
		end
		// stopped output for a couple of sample periods
		repeat (2 * (SAMPLE_DIV + 1)) @(negedge clk_sys);

		total = tb_errors + i_snes_cart_top.i_snes_cart_assert.fail_cnt;
		$display("errors: %0d testbench, %0d assertion", tb_errors,
			i_snes_cart_top.i_snes_cart_assert.fail_cnt);
		if (total == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
